//--- sens_io_params.svh
/*
 * Sensor front end I/O parameters
 * command address decode, register field positions, counter widths
 * and the sensor clock divisor
 */
`ifndef SENS_IO_PARAMS_SVH
`define SENS_IO_PARAMS_SVH

`define SENSIO_ADDR       16'h0330   // base of the register window
`define SENSIO_ADDR_MASK  16'h07f8   // low 3 bits select the register

`define SENSIO_CTRL       3'h0       // sensor control register
`define SENSIO_JTAG       3'h2       // external FPGA programming pins
`define SENSIO_SKIP       3'h3       // lines to hide per frame

// control register, enable bit sits just above each value
`define CTRL_MRST         0          // 1:0
`define CTRL_ARST         2          // 3:2
`define CTRL_ARO          4          // 5:4
`define CTRL_GP0          12         // 14:12, mode + enable
`define CTRL_GP1          15         // 17:15, mode + enable

// jtag register, same value/enable pairing
`define JTAG_TDI          0
`define JTAG_TMS          2
`define JTAG_TCK          4
`define JTAG_PROG         6
`define JTAG_PGMEN        8

`define CMD_BYTES         6          // AL, AH, D0..D3
`define SKIP_BITS         8          // line skip counter width
`define PXD_CLK_DIV       10         // pclk / sensor clock

`endif

//--- sens_io_reg_pkg.sv
/*
 * Register side types of the sensor I/O block
 * command address and data, deserializer states and the
 * decoded control, JTAG and line skip fields
 */
`include "sens_io_params.svh"

package sens_io_reg_pkg;

    typedef logic [2:0]  reg_addr_t;   // register number
    typedef logic [31:0] reg_data_t;   // register payload

    typedef enum logic [1:0] {
        CMD_IDLE,                      // waiting for strobe
        CMD_ADDR_HI,                   // next byte is address high
        CMD_DATA                       // collecting D0..D3
    } cmd_state_e;

    typedef logic [1:0] gp_mode_t;     // 00 float, 01 low, 10 high, 11 trigger

    localparam gp_mode_t GP_FLOAT = 2'b00;
    localparam gp_mode_t GP_TRIG  = 2'b11;

    typedef struct packed {
        logic     imrst;               // sensor master reset, active low
        logic     iarst;               // analog reset
        logic     aro_soft;            // ARO level in free running mode
        gp_mode_t gp0_mode;
        gp_mode_t gp1_mode;
    } sens_ctrl_t;

    typedef struct packed {
        logic pgmen;                   // pins belong to the external FPGA
        logic prog;                    // PROG_B, inverted at the pin
        logic tck;
        logic tms;
        logic tdi;
    } jtag_t;

    typedef logic [`SKIP_BITS-1:0] skip_cnt_t;

endpackage

//--- sens_io_pin_pkg.sv
/*
 * Pin side types of the sensor I/O block
 * pixel word, sensor pin bundle with output enables, status word
 */
package sens_io_pin_pkg;

    typedef logic [11:0] pixel_t;

    typedef struct packed {
        logic mrst;        // sensor master reset pin
        logic arst_tms;    // analog reset or TMS
        logic ctl_tck;     // ARO or TCK
        logic gp0;         // GP0 or TDI
        logic gp0_oe;
        logic gp1;
        logic gp1_oe;
        logic pgm;         // PROGRAM of the external FPGA
        logic pgm_oe;
    } sens_pins_t;

    typedef struct packed {
        logic done;        // shutter done or FPGA DONE
        logic tdo;         // flash or FPGA TDO
        logic pgm_in;      // PROGRAM pin readback
        logic hact_alive;  // line seen since last clear
    } sens_status_t;

endpackage

//--- sens_io_cmd_deser.sv
/*
 * Byte-serial command deserializer
 * collects AL, AH and four little-endian data bytes, compares the
 * address with the block window and pulses a write
 */
`timescale 1ns/1ps
`include "sens_io_params.svh"

module sens_io_cmd_deser (
    input  logic                       pclk,
    input  logic                       async_prst_with_sens_mrst,
    input  logic [7:0]                 cmd_ad_i,   // address/data byte
    input  logic                       cmd_stb_i,  // marks the first byte
    output sens_io_reg_pkg::reg_addr_t addr_o,
    output sens_io_reg_pkg::reg_data_t data_o,
    output logic                       we_o
);
    localparam int CNT_W = $clog2(`CMD_BYTES);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(`CMD_BYTES - 1);

    sens_io_reg_pkg::cmd_state_e state;
    logic [CNT_W-1:0]            byte_cnt;  // bytes taken so far
    logic [15:0]                 addr_sr;
    sens_io_reg_pkg::reg_data_t  data_sr;
    logic                        addr_match;

    assign addr_match = (addr_sr & `SENSIO_ADDR_MASK) == (`SENSIO_ADDR & `SENSIO_ADDR_MASK);
    assign addr_o     = addr_sr[2:0];  // register select
    assign data_o     = data_sr;

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            state    <= sens_io_reg_pkg::CMD_IDLE;
            byte_cnt <= '0;
            we_o     <= 1'b0;
        end else begin
            we_o <= 1'b0;
            if (cmd_stb_i) begin  // restarts any command in flight
                state    <= sens_io_reg_pkg::CMD_ADDR_HI;
                byte_cnt <= CNT_W'(1);
            end else begin
                case (state)
                    sens_io_reg_pkg::CMD_ADDR_HI: begin
                        state    <= sens_io_reg_pkg::CMD_DATA;
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                    sens_io_reg_pkg::CMD_DATA: begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == LAST_BYTE) begin  // D3 on the bus
                            state <= sens_io_reg_pkg::CMD_IDLE;
                            we_o  <= addr_match;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (cmd_stb_i)
            addr_sr[7:0] <= cmd_ad_i;
        if (!cmd_stb_i && state == sens_io_reg_pkg::CMD_ADDR_HI)
            addr_sr[15:8] <= cmd_ad_i;
        if (!cmd_stb_i && state == sens_io_reg_pkg::CMD_DATA)
            data_sr <= {cmd_ad_i, data_sr[31:8]};  // D0 ends up in the low byte
    end

    // one write per command, even back to back
    a_we_single: assert property (@(posedge pclk) disable iff (async_prst_with_sens_mrst)
        we_o |=> !we_o);

endmodule

//--- sens_io_regs.sv
/*
 * Register decode and field storage
 * data and per-register strobes are registered once, then each
 * field loads only when its enable bit is set in the data word
 */
`timescale 1ns/1ps
`include "sens_io_params.svh"

module sens_io_regs (
    input  logic                       pclk,
    input  logic                       async_prst_with_sens_mrst,
    input  sens_io_reg_pkg::reg_addr_t addr_i,
    input  sens_io_reg_pkg::reg_data_t data_i,
    input  logic                       we_i,
    output sens_io_reg_pkg::sens_ctrl_t ctrl_o,
    output sens_io_reg_pkg::jtag_t     jtag_o,
    output sens_io_reg_pkg::skip_cnt_t lines_skip_o,
    output logic                       skip_wr_o
);
    sens_io_reg_pkg::reg_data_t data_r;  // command payload
    logic                       set_ctrl_r;
    logic                       set_jtag_r;
    logic                       set_skip_r;

    assign skip_wr_o = set_skip_r;

    always_ff @(posedge pclk) begin
        if (we_i)
            data_r <= data_i;
    end

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            set_ctrl_r <= 1'b0;
            set_jtag_r <= 1'b0;
            set_skip_r <= 1'b0;
        end else begin
            set_ctrl_r <= we_i && (addr_i == `SENSIO_CTRL);
            set_jtag_r <= we_i && (addr_i == `SENSIO_JTAG);
            set_skip_r <= we_i && (addr_i == `SENSIO_SKIP);
        end
    end

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            ctrl_o       <= '0;  // mrst low keeps the sensor in reset
            jtag_o       <= '0;
            lines_skip_o <= '0;
        end else begin
            if (set_ctrl_r) begin
                if (data_r[`CTRL_MRST+1]) ctrl_o.imrst    <= data_r[`CTRL_MRST];
                if (data_r[`CTRL_ARST+1]) ctrl_o.iarst    <= data_r[`CTRL_ARST];
                if (data_r[`CTRL_ARO+1])  ctrl_o.aro_soft <= data_r[`CTRL_ARO];  // own enable
                if (data_r[`CTRL_GP0+2])  ctrl_o.gp0_mode <= data_r[`CTRL_GP0 +: 2];
                if (data_r[`CTRL_GP1+2])  ctrl_o.gp1_mode <= data_r[`CTRL_GP1 +: 2];
            end
            if (set_jtag_r) begin
                if (data_r[`JTAG_PGMEN+1]) jtag_o.pgmen <= data_r[`JTAG_PGMEN];
                if (data_r[`JTAG_PROG+1])  jtag_o.prog  <= data_r[`JTAG_PROG];
                if (data_r[`JTAG_TCK+1])   jtag_o.tck   <= data_r[`JTAG_TCK];
                if (data_r[`JTAG_TMS+1])   jtag_o.tms   <= data_r[`JTAG_TMS];
                if (data_r[`JTAG_TDI+1])   jtag_o.tdi   <= data_r[`JTAG_TDI];
            end
            if (set_skip_r)  // no enable bit here
                lines_skip_o <= data_r[`SKIP_BITS-1:0];
        end
    end

endmodule

//--- sens_io_pin_mux.sv
/*
 * Sensor and JTAG pin drive
 * selects sensor control or external FPGA programming on the shared
 * pins, applies the GP modes and probes PROGRAM after programming
 */
`timescale 1ns/1ps

module sens_io_pin_mux (
    input  logic                        pclk,
    input  logic                        async_prst_with_sens_mrst,
    input  sens_io_reg_pkg::sens_ctrl_t ctrl_i,
    input  sens_io_reg_pkg::jtag_t      jtag_i,
    input  logic                        trig_i,          // per-sensor trigger
    input  logic                        trigger_mode_i,  // 0 free running
    input  logic                        pgm_i,           // PROGRAM pin readback
    output sens_io_pin_pkg::sens_pins_t pins_o
);
    logic       aro;
    logic [1:0] pgmen_d;      // pgmen history
    logic       force_pgm;    // hold PROGRAM high after programming

    // pin level for a GP mode, trigger mode takes the given signal
    function automatic logic gp_level(sens_io_reg_pkg::gp_mode_t mode, logic trig_lvl);
        return (mode == sens_io_reg_pkg::GP_TRIG) ? trig_lvl : mode[1];
    endfunction

    assign aro = trigger_mode_i ? ~trig_i : ctrl_i.aro_soft;

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            pgmen_d   <= 2'b00;
            force_pgm <= 1'b0;
        end else begin
            pgmen_d <= {pgmen_d[0], jtag_i.pgmen};
            if (pgmen_d == 2'b10)  // one cycle after pgmen dropped
                force_pgm <= pgm_i;
        end
    end

    always_comb begin
        pins_o.mrst   = ctrl_i.imrst;
        pins_o.gp1    = gp_level(ctrl_i.gp1_mode, ~aro);
        pins_o.gp1_oe = ctrl_i.gp1_mode != sens_io_reg_pkg::GP_FLOAT;
        if (jtag_i.pgmen) begin
            pins_o.ctl_tck  = jtag_i.tck;
            pins_o.arst_tms = jtag_i.tms;
            pins_o.gp0      = jtag_i.tdi;
            pins_o.gp0_oe   = 1'b1;
            pins_o.pgm      = ~jtag_i.prog;  // PROG_B is active low
            pins_o.pgm_oe   = 1'b1;
        end else begin
            pins_o.ctl_tck  = aro;
            pins_o.arst_tms = ctrl_i.iarst;
            pins_o.gp0      = gp_level(ctrl_i.gp0_mode, aro);
            pins_o.gp0_oe   = ctrl_i.gp0_mode != sens_io_reg_pkg::GP_FLOAT;
            pins_o.pgm      = force_pgm;
            pins_o.pgm_oe   = force_pgm;     // float to read DONE
        end
    end

    a_gp1_float: assert property (@(posedge pclk) disable iff (async_prst_with_sens_mrst)
        (!jtag_i.pgmen && ctrl_i.gp1_mode == sens_io_reg_pkg::GP_FLOAT) |-> !pins_o.gp1_oe);

endmodule

//--- sens_io_ext_clk.sv
/*
 * Sensor clock divider
 * half-period down-counter toggles the MSB for a 50 % duty clock
 */
`timescale 1ns/1ps
`include "sens_io_params.svh"

module sens_io_ext_clk (
    input  logic pclk,
    input  logic async_prst_with_sens_mrst,
    output logic ext_clk_o
);
    localparam int HALF = `PXD_CLK_DIV / 2;
    localparam int CW   = $clog2(HALF);

    logic [CW:0] cnt;  // msb is the clock, low bits count the half period

    assign ext_clk_o = cnt[CW];

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            cnt <= {1'b0, CW'(HALF - 1)};  // starts low
        end else if (cnt[CW-1:0] == '0) begin
            cnt <= {~cnt[CW], CW'(HALF - 1)};
        end else begin
            cnt[CW-1:0] <= cnt[CW-1:0] - 1'b1;
        end
    end

endmodule

//--- sens_io_line_skip.sv
/*
 * Line skipper
 * hides the first N lines of every frame from hact and flags that
 * lines are arriving at all
 */
`timescale 1ns/1ps

module sens_io_line_skip (
    input  logic                       pclk,
    input  logic                       async_prst_with_sens_mrst,
    input  sens_io_reg_pkg::skip_cnt_t lines_skip_i,
    input  logic                       skip_wr_i,   // skip register written
    input  logic                       hact_i,
    input  logic                       sof_i,
    output logic                       hact_o,
    output logic                       hact_alive_o
);
    sens_io_reg_pkg::skip_cnt_t lines_cntr;   // lines left to hide
    logic                       some_skip;
    logic                       hact_r;
    logic                       hact_dis;     // masks hact while skipping
    logic                       hact_fall;

    assign hact_fall = hact_r && !hact_i;     // end of a line
    assign hact_o    = hact_i && !hact_dis;

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            hact_r       <= 1'b0;
            some_skip    <= 1'b0;
            lines_cntr   <= '0;
            hact_dis     <= 1'b0;
            hact_alive_o <= 1'b0;
        end else begin
            hact_r    <= hact_i;
            some_skip <= |lines_skip_i;  // count sampled a cycle late

            if (!some_skip)
                lines_cntr <= '0;
            else if (sof_i)
                lines_cntr <= lines_skip_i;
            else if ((|lines_cntr) && hact_fall)
                lines_cntr <= lines_cntr - 1'b1;

            if (!some_skip)
                hact_dis <= 1'b0;
            else if (sof_i)
                hact_dis <= 1'b1;
            else if ((lines_cntr <= 1) && hact_fall)  // last hidden line ends
                hact_dis <= 1'b0;

            if (skip_wr_i)
                hact_alive_o <= 1'b0;
            else if (hact_i && !hact_r)
                hact_alive_o <= 1'b1;
        end
    end

    // counter must not wrap below zero
    a_no_underflow: assert property (@(posedge pclk) disable iff (async_prst_with_sens_mrst)
        (lines_cntr == '0 && !sof_i) |=> lines_cntr == '0);

endmodule

//--- sens_io_top.sv
/*
 * Sensor front end control and I/O top
 * command deserializer, registers, pin drive, sensor clock and
 * line skipper on pclk, with a parallel status word
 */
`timescale 1ns/1ps

module sens_io_top (
    input  logic                          pclk,
    input  logic                          async_prst_with_sens_mrst,
    input  logic [7:0]                    cmd_ad_i,
    input  logic                          cmd_stb_i,
    input  logic                          trig_i,
    input  logic                          trigger_mode_i,
    input  logic                          pgm_i,
    input  logic                          flash_tdo_i,
    input  logic                          shutter_done_i,
    input  sens_io_pin_pkg::pixel_t       pxd_i,
    input  logic                          hact_i,
    input  logic                          sof_i,
    input  logic                          eof_i,
    output sens_io_pin_pkg::sens_pins_t   pins_o,
    output logic                          ext_clk_p_o,
    output logic                          ext_clk_n_o,
    output sens_io_pin_pkg::pixel_t       pxd_o,
    output logic                          hact_o,
    output logic                          sof_o,
    output logic                          eof_o,
    output sens_io_pin_pkg::sens_status_t status_o
);
    sens_io_reg_pkg::reg_addr_t  cmd_addr;
    sens_io_reg_pkg::reg_data_t  cmd_data;
    logic                        cmd_we;
    sens_io_reg_pkg::sens_ctrl_t ctrl;
    sens_io_reg_pkg::jtag_t      jtag;
    sens_io_reg_pkg::skip_cnt_t  lines_skip;
    logic                        skip_wr;
    logic                        hact_alive;

    assign ext_clk_n_o = ctrl.iarst;  // quiet pin, carries analog reset
    assign pxd_o       = pxd_i;
    assign sof_o       = sof_i;
    assign eof_o       = eof_i;
    assign status_o    = '{done: shutter_done_i, tdo: flash_tdo_i,
                           pgm_in: pgm_i, hact_alive: hact_alive};

    sens_io_cmd_deser u_cmd_deser (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .cmd_ad_i                  (cmd_ad_i),
        .cmd_stb_i                 (cmd_stb_i),
        .addr_o                    (cmd_addr),
        .data_o                    (cmd_data),
        .we_o                      (cmd_we)
    );

    sens_io_regs u_regs (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .addr_i                    (cmd_addr),
        .data_i                    (cmd_data),
        .we_i                      (cmd_we),
        .ctrl_o                    (ctrl),
        .jtag_o                    (jtag),
        .lines_skip_o              (lines_skip),
        .skip_wr_o                 (skip_wr)
    );

    sens_io_pin_mux u_pin_mux (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .ctrl_i                    (ctrl),
        .jtag_i                    (jtag),
        .trig_i                    (trig_i),
        .trigger_mode_i            (trigger_mode_i),
        .pgm_i                     (pgm_i),
        .pins_o                    (pins_o)
    );

    sens_io_ext_clk u_ext_clk (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .ext_clk_o                 (ext_clk_p_o)
    );

    sens_io_line_skip u_line_skip (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .lines_skip_i              (lines_skip),
        .skip_wr_i                 (skip_wr),
        .hact_i                    (hact_i),
        .sof_i                     (sof_i),
        .hact_o                    (hact_o),
        .hact_alive_o              (hact_alive)
    );

endmodule

//--- tb_sens_io_ref.svh
/*
 * Reference model of the sensor I/O block
 * register field updates, expected pins, status and line visibility
 */
`ifndef TB_SENS_IO_REF_SVH
`define TB_SENS_IO_REF_SVH

function automatic logic addr_hits(logic [15:0] a);
    return (a & `SENSIO_ADDR_MASK) == (`SENSIO_ADDR & `SENSIO_ADDR_MASK);  // window compare
endfunction

function automatic sens_io_reg_pkg::sens_ctrl_t ctrl_next(sens_io_reg_pkg::sens_ctrl_t c,
                                                          logic [31:0] d);
    sens_io_reg_pkg::sens_ctrl_t n;
    n = c;
    if (d[`CTRL_MRST+1]) n.imrst = d[`CTRL_MRST];
    if (d[`CTRL_ARST+1]) n.iarst = d[`CTRL_ARST];
    if (d[`CTRL_ARO+1]) n.aro_soft = d[`CTRL_ARO];
    if (d[`CTRL_GP0+2]) n.gp0_mode = d[`CTRL_GP0 +: 2];  // two-bit mode, enable above
    if (d[`CTRL_GP1+2]) n.gp1_mode = d[`CTRL_GP1 +: 2];
    return n;
endfunction

function automatic sens_io_reg_pkg::jtag_t jtag_next(sens_io_reg_pkg::jtag_t j, logic [31:0] d);
    sens_io_reg_pkg::jtag_t n;
    n = j;
    if (d[`JTAG_TDI+1]) n.tdi = d[`JTAG_TDI];
    if (d[`JTAG_TMS+1]) n.tms = d[`JTAG_TMS];
    if (d[`JTAG_TCK+1]) n.tck = d[`JTAG_TCK];
    if (d[`JTAG_PROG+1]) n.prog = d[`JTAG_PROG];
    if (d[`JTAG_PGMEN+1]) n.pgmen = d[`JTAG_PGMEN];
    return n;
endfunction

// {oe, level} for one GP pin
function automatic logic [1:0] gp_drive(logic [1:0] mode, logic trig_lvl);
    case (mode)
        2'b00:   return 2'b00;           // floating
        2'b01:   return 2'b10;           // driven low
        2'b10:   return 2'b11;           // driven high
        default: return {1'b1, trig_lvl};
    endcase
endfunction

function automatic sens_io_pin_pkg::sens_pins_t exp_pins(sens_io_reg_pkg::sens_ctrl_t c,
        sens_io_reg_pkg::jtag_t j, logic trig, logic tmode, logic force_pgm);
    sens_io_pin_pkg::sens_pins_t p;
    logic                        aro;
    aro = tmode ? !trig : c.aro_soft;
    p = '0;
    p.mrst = c.imrst;
    {p.gp1_oe, p.gp1} = gp_drive(c.gp1_mode, !aro);  // gp1 gets inverted ARO
    if (j.pgmen) begin
        p.ctl_tck  = j.tck;
        p.arst_tms = j.tms;
        {p.gp0_oe, p.gp0} = {1'b1, j.tdi};
        {p.pgm_oe, p.pgm} = {1'b1, !j.prog};
    end else begin
        p.ctl_tck  = aro;
        p.arst_tms = c.iarst;
        {p.gp0_oe, p.gp0} = gp_drive(c.gp0_mode, aro);
        {p.pgm_oe, p.pgm} = {force_pgm, force_pgm};   // probe holds PROGRAM high
    end
    return p;
endfunction

// a floating pin has no defined level
function automatic sens_io_pin_pkg::sens_pins_t mask_floating(sens_io_pin_pkg::sens_pins_t p);
    sens_io_pin_pkg::sens_pins_t m;
    m = p;
    if (!m.gp0_oe) m.gp0 = 1'b0;
    if (!m.gp1_oe) m.gp1 = 1'b0;
    if (!m.pgm_oe) m.pgm = 1'b0;
    return m;
endfunction

function automatic sens_io_pin_pkg::sens_status_t exp_status(logic done, logic tdo,
                                                             logic pgm, logic alive);
    sens_io_pin_pkg::sens_status_t s;
    s.done       = done;
    s.tdo        = tdo;
    s.pgm_in     = pgm;
    s.hact_alive = alive;
    return s;
endfunction

function automatic logic line_shown(int ln, sens_io_reg_pkg::skip_cnt_t n);
    return ln >= int'(n);  // first n lines of a frame hidden
endfunction

`endif

//--- tb_sens_io.sv
/*
 * Testbench of the sensor I/O top
 * byte-serial register writes, pin mux modes, JTAG and PROGRAM probe,
 * line skipping, sensor clock and status, checked against a model
 */
`timescale 1ns/1ps
`include "sens_io_params.svh"

module tb_sens_io;
    localparam int          CYCLE_LIMIT = 20000;  // tests need a few thousand cycles
    localparam int          N_RAND      = 150;    // random control writes
    localparam logic [15:0] BASE        = `SENSIO_ADDR;

    logic pclk = 1'b0;
    logic async_prst_with_sens_mrst;
    logic [7:0] cmd_ad_i;
    logic cmd_stb_i, trig_i, trigger_mode_i, pgm_i, flash_tdo_i, shutter_done_i;
    sens_io_pin_pkg::pixel_t pxd_i, pxd_o;
    logic hact_i, sof_i, eof_i, hact_o, sof_o, eof_o;
    logic ext_clk_p_o, ext_clk_n_o;
    sens_io_pin_pkg::sens_pins_t   pins_o;
    sens_io_pin_pkg::sens_status_t status_o;

    sens_io_reg_pkg::sens_ctrl_t model_ctrl  = '0;  // fields as the DUT should hold them
    sens_io_reg_pkg::jtag_t      model_jtag  = '0;
    sens_io_reg_pkg::skip_cnt_t  model_skip  = '0;
    logic                        model_force = 1'b0;
    logic                        model_alive = 1'b0;
    logic chk_en   = 1'b0;
    logic chk_hact = 1'b0;
    logic exp_hact = 1'b0;
    logic clk_prev = 1'b0;
    int   cycles   = 0;
    int   rises    = 0;
    int   period   = 0;
    int   high     = 0;
    int   skip_list[3] = '{0, 1, 3};

    `include "tb_sens_io_ref.svh"

    sens_io_top UUT (.*);

    always #20 pclk = ~pclk;

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
            $display("Test FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic [15:0] reg_addr(logic [2:0] r);
        return {BASE[15:3], r};
    endfunction

    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] bytes;
        bytes = {data, addr};                 // AL first, D3 last
        for (int b = 0; b < `CMD_BYTES; b++) begin
            @(negedge pclk);
            cmd_stb_i = (b == 0);
            cmd_ad_i  = bytes[8*b +: 8];
        end
        @(negedge pclk);
        cmd_ad_i = 8'h00;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        sens_io_reg_pkg::jtag_t j_new;
        chk_en = 1'b0;                        // outputs in transit
        send_cmd(addr, data);
        repeat (5) @(negedge pclk);
        if (addr_hits(addr)) begin
            case (addr[2:0])
                `SENSIO_CTRL: model_ctrl = ctrl_next(model_ctrl, data);
                `SENSIO_JTAG: begin
                    j_new = jtag_next(model_jtag, data);
                    if (model_jtag.pgmen && !j_new.pgmen)
                        model_force = pgm_i;  // probe on programming exit
                    model_jtag = j_new;
                end
                `SENSIO_SKIP: begin
                    model_skip  = data[`SKIP_BITS-1:0];
                    model_alive = 1'b0;
                end
                default: ;
            endcase
        end
        chk_en = 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge pclk);
            trig_i         = 1'($urandom);
            shutter_done_i = 1'($urandom);
            flash_tdo_i    = 1'($urandom);
        end
    endtask

    task automatic run_frame(input int n_lines);
        chk_hact = 1'b1;
        @(negedge pclk);
        sof_i = 1'b1;
        @(negedge pclk);
        sof_i = 1'b0;
        repeat (2) @(negedge pclk);
        for (int ln = 0; ln < n_lines; ln++) begin
            for (int c = 0; c < 12; c++) begin  // 8 active, 4 blank
                hact_i   = (c < 8);
                exp_hact = hact_i && line_shown(ln, model_skip);
                pxd_i    = 12'($urandom);
                if (c == 1)
                    model_alive = 1'b1;       // one edge after the rise
                @(negedge pclk);
            end
        end
        eof_i = 1'b1;
        @(negedge pclk);
        eof_i    = 1'b0;
        chk_hact = 1'b0;
    endtask

    // samples before the edge updates anything
    always @(posedge pclk) begin
        if (!async_prst_with_sens_mrst) begin
            if (chk_en) begin
                check(32'(mask_floating(pins_o)), 32'(mask_floating(exp_pins(model_ctrl,
                      model_jtag, trig_i, trigger_mode_i, model_force))), "pins_o");
                check(32'(ext_clk_n_o), 32'(model_ctrl.iarst), "ext_clk_n_o");
                check(32'(status_o), 32'(exp_status(shutter_done_i, flash_tdo_i, pgm_i,
                      model_alive)), "status_o");
            end
            if (chk_hact)
                check(32'(hact_o), 32'(exp_hact), "hact_o");
            check(32'(pxd_o), 32'(pxd_i), "pxd_o");
            check(32'({sof_o, eof_o}), 32'({sof_i, eof_i}), "sof_o/eof_o");
            if (!clk_prev && ext_clk_p_o) begin  // rising sensor clock
                if (rises > 0) begin
                    check(32'(period), 32'(`PXD_CLK_DIV), "ext_clk_p_o period");
                    check(32'(high), 32'(`PXD_CLK_DIV / 2), "ext_clk_p_o high time");
                end
                rises++;
                period = 0;
                high   = 0;
            end
            period++;
            if (ext_clk_p_o)
                high++;
            clk_prev = ext_clk_p_o;
        end
    end

    always @(posedge pclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $fatal(1, "run did not finish");
        end
    end

    initial begin
        logic [31:0]            d;
        logic [15:0]            a;
        sens_io_reg_pkg::jtag_t jv;
        void'($urandom(32'h3cf2_eeed));
        async_prst_with_sens_mrst = 1'b1;
        cmd_ad_i = 8'h00;
        cmd_stb_i = 1'b0;
        trig_i = 1'b0;
        trigger_mode_i = 1'b0;
        pgm_i = 1'b0;
        flash_tdo_i = 1'b0;
        shutter_done_i = 1'b0;
        pxd_i = '0;
        hact_i = 1'b0;
        sof_i = 1'b0;
        eof_i = 1'b0;
        repeat (2) @(negedge pclk);
        async_prst_with_sens_mrst = 1'b0;
        check(32'(ext_clk_p_o), 32'd0, "ext_clk_p_o after reset");
        chk_en = 1'b1;

        for (int i = 0; i < N_RAND; i++) begin  // random control writes with some missing the window
            trigger_mode_i = 1'($urandom);
            d = $urandom;
            if ($urandom_range(3, 0) == 0)
                a = {BASE[15:3] ^ (13'd1 << $urandom_range(7, 0)), 3'($urandom)};
            else
                a = reg_addr(`SENSIO_CTRL);
            write_reg(a, d);
            idle(3);
        end

        for (int tm = 0; tm < 2; tm++) begin  // every GP mode in both trigger modes
            for (int m = 0; m < 4; m++) begin
                trigger_mode_i = 1'(tm);
                d = $urandom;
                d[`CTRL_GP0 +: 3] = {1'b1, 2'(m)};
                d[`CTRL_GP1 +: 3] = {1'b1, 2'(3 - m)};
                write_reg(reg_addr(`SENSIO_CTRL), d);
                idle(10);
            end
        end

        for (int k = 0; k < 4; k++) begin  // program mode then exit with pgm_i high and low
            for (int n = 0; n < 4; n++) begin
                jv = sens_io_reg_pkg::jtag_t'(5'($urandom));
                jv.pgmen = 1'b1;
                write_reg(reg_addr(`SENSIO_JTAG), jtag_word(jv));
                idle(4);
            end
            pgm_i = 1'(k % 2 == 0);
            jv.pgmen = 1'b0;
            write_reg(reg_addr(`SENSIO_JTAG), jtag_word(jv));
            idle(8);
        end

        foreach (skip_list[s]) begin
            write_reg(reg_addr(`SENSIO_SKIP), {24'($urandom), 8'(skip_list[s])});
            run_frame(6);
            run_frame(6);
            idle(4);
        end

        check(32'(rises > 2), 32'd1, "ext_clk_p_o toggling");
        $display("Test OK");
        $finish;
    end

    // register word with every JTAG enable set
    function automatic logic [31:0] jtag_word(sens_io_reg_pkg::jtag_t v);
        logic [31:0] d;
        d = '0;
        d[`JTAG_TDI +: 2]   = {1'b1, v.tdi};
        d[`JTAG_TMS +: 2]   = {1'b1, v.tms};
        d[`JTAG_TCK +: 2]   = {1'b1, v.tck};
        d[`JTAG_PROG +: 2]  = {1'b1, v.prog};
        d[`JTAG_PGMEN +: 2] = {1'b1, v.pgmen};
        return d;
    endfunction

endmodule

//--- sens_io.f
+incdir+.
sens_io_reg_pkg.sv
sens_io_pin_pkg.sv
sens_io_cmd_deser.sv
sens_io_regs.sv
sens_io_pin_mux.sv
sens_io_ext_clk.sv
sens_io_line_skip.sv
sens_io_top.sv
tb_sens_io.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_sens_io
FILELIST  = sens_io.f
BUILD_DIR = obj_dir
LOG       = run.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
